// ==== Makefile ====
VERILATOR  := verilator
TOP        := bias_tb
FILELIST   := bias_top.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== bias_top.f ====
+incdir+include
logic/bias_pkg.sv
logic/des_round.sv
logic/des_pipeline.sv
logic/msg_lfsr.sv
logic/bias_config.sv
logic/bias_block.sv
logic/bias_top.sv
test/bias_props.sv
test/bias_tb.sv

// ==== include/des_tables.svh ====
// DES numbers bits from 1 at the leftmost position
// so table entry n picks vector index (width - n)

function automatic logic [63:0] des_ip(input logic [63:0] din);
    int          tbl [64];
    logic [63:0] dout;
    tbl = '{58, 50, 42, 34, 26, 18, 10, 2,
            60, 52, 44, 36, 28, 20, 12, 4,
            62, 54, 46, 38, 30, 22, 14, 6,
            64, 56, 48, 40, 32, 24, 16, 8,
            57, 49, 41, 33, 25, 17, 9,  1,
            59, 51, 43, 35, 27, 19, 11, 3,
            61, 53, 45, 37, 29, 21, 13, 5,
            63, 55, 47, 39, 31, 23, 15, 7};
    for (int i = 0; i < 64; i++) begin
        dout[63-i] = din[64-tbl[i]];
    end
    return dout;
endfunction

// Inverse of des_ip
function automatic logic [63:0] des_fp(input logic [63:0] din);
    int          tbl [64];
    logic [63:0] dout;
    tbl = '{40, 8, 48, 16, 56, 24, 64, 32,
            39, 7, 47, 15, 55, 23, 63, 31,
            38, 6, 46, 14, 54, 22, 62, 30,
            37, 5, 45, 13, 53, 21, 61, 29,
            36, 4, 44, 12, 52, 20, 60, 28,
            35, 3, 43, 11, 51, 19, 59, 27,
            34, 2, 42, 10, 50, 18, 58, 26,
            33, 1, 41, 9,  49, 17, 57, 25};
    for (int i = 0; i < 64; i++) begin
        dout[63-i] = din[64-tbl[i]];
    end
    return dout;
endfunction

// Right half 32 -> 48 with the edge bits of each nibble repeated
function automatic logic [47:0] des_expand(input logic [31:0] din);
    int          tbl [48];
    logic [47:0] dout;
    tbl = '{32, 1,  2,  3,  4,  5,
            4,  5,  6,  7,  8,  9,
            8,  9,  10, 11, 12, 13,
            12, 13, 14, 15, 16, 17,
            16, 17, 18, 19, 20, 21,
            20, 21, 22, 23, 24, 25,
            24, 25, 26, 27, 28, 29,
            28, 29, 30, 31, 32, 1};
    for (int i = 0; i < 48; i++) begin
        dout[47-i] = din[32-tbl[i]];
    end
    return dout;
endfunction

function automatic logic [31:0] des_perm_p(input logic [31:0] din);
    int          tbl [32];
    logic [31:0] dout;
    tbl = '{16, 7,  20, 21, 29, 12, 28, 17,
            1,  15, 23, 26, 5,  18, 31, 10,
            2,  8,  24, 14, 32, 27, 3,  9,
            19, 13, 30, 6,  22, 11, 4,  25};
    for (int i = 0; i < 32; i++) begin
        dout[31-i] = din[32-tbl[i]];
    end
    return dout;
endfunction

// All eight S-boxes, S1 on the leftmost six bits
// Row is outer bit pair, column the middle four, so row*16+col = {b5, b0, b4:b1}
function automatic logic [31:0] des_sbox(input logic [47:0] din);
    int          tbl [8][64];
    logic [5:0]  six;
    logic [31:0] dout;
    tbl = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };
    for (int b = 0; b < 8; b++) begin
        six = din[47-6*b -: 6];
        dout[31-4*b -: 4] = 4'(tbl[b][{six[5], six[0], six[4:1]}]);
    end
    return dout;
endfunction

// ==== logic/bias_block.sv ====
module bias_block #(
    parameter logic [767:0] ROUND_KEYS = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,    // One-cycle run request
    input  logic                       restart,  // Back to idle, count cleared
    input  bias_pkg::bias_cfg_t        held_cfg,
    output logic                       capture,  // Start taken in idle
    output logic [bias_pkg::cnt_w-1:0] count,    // Pairs with odd combined parity
    output logic                       done      // Level, until restart
);
    import bias_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_running,
        st_draining,
        st_finished
    } state_t;

    localparam int drain_w = $clog2(des_latency + 1);

    state_t                 state;
    state_t                 next_state;
    logic [drain_w-1:0]     drain_left;   // Cycles until the last cipher is counted
    logic [63:0]            message;
    logic                   msg_valid;
    logic                   last;
    logic [63:0]            cipher;
    logic                   cipher_valid;
    logic [des_latency-1:0] par_line;     // Input parity, aligned to the pipeline
    logic                   par_q;        // Combined parity, registered
    logic                   valid_q;      // cipher_valid, registered

    assign capture = (state == st_idle) && start;
    assign done    = (state == st_finished);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start) begin
                    next_state = st_running;
                end
            end
            st_running: begin  // !msg_valid only here when limit is 0
                if (last || !msg_valid) begin
                    next_state = st_draining;
                end
            end
            st_draining: begin  // Short runs leave gaps in cipher_valid, hence the timer
                if (drain_left == '0 && !cipher_valid) begin
                    next_state = st_finished;
                end
            end
            default: next_state = state;  // Finished holds until restart
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // Reloaded outside draining, counts down inside it
    always_ff @(posedge clk) begin
        if (!rst_n || state != st_draining) begin
            drain_left <= drain_w'(des_latency);
        end else if (drain_left != '0) begin
            drain_left <= drain_left - 1'b1;
        end
    end

    msg_lfsr i_lfsr (
        .clk        (clk),
        .rst_n      (rst_n),
        .restart    (restart),
        .load       (capture),
        .seed       (held_cfg.seed),
        .polynomial (held_cfg.polynomial),
        .limit      (held_cfg.limit),
        .message    (message),
        .msg_valid  (msg_valid),
        .last       (last)
    );

    des_pipeline #(
        .ROUND_KEYS (ROUND_KEYS)
    ) i_des (
        .clk          (clk),
        .rst_n        (rst_n),
        .restart      (restart),
        .message      (message),
        .msg_valid    (msg_valid),
        .cipher       (cipher),
        .cipher_valid (cipher_valid)
    );

    // Fixed latency, so shifting every cycle keeps the top bit on its cipher
    always_ff @(posedge clk) begin
        par_line <= {par_line[des_latency-2:0], masked_parity(message, held_cfg.mask_in)};
        par_q    <= par_line[des_latency-1] ^ masked_parity(cipher, held_cfg.mask_out);
    end

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            valid_q <= 1'b0;
            count   <= '0;
        end else begin
            valid_q <= cipher_valid;
            if (valid_q && par_q) begin
                count <= count + 1'b1;  // One cycle after cipher_valid
            end
        end
    end

endmodule

// ==== logic/bias_config.sv ====
module bias_config (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                restart,
    input  logic                capture,  // Start accepted this cycle
    input  bias_pkg::bias_cfg_t cfg,
    output bias_pkg::bias_cfg_t held_cfg
);
    import bias_pkg::*;

    bias_cfg_t cfg_q;  // Config of the current run

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            cfg_q <= '0;
        end else if (capture) begin
            cfg_q <= cfg;
        end
    end

    // The LFSR loads on the capture edge itself,
    // so the incoming config is passed straight through during that cycle
    assign held_cfg = capture ? cfg : cfg_q;

endmodule

// ==== logic/bias_pkg.sv ====
package bias_pkg;

    // Width of the message limit and of the bias count
    localparam int cnt_w = 32;

    // Plaintext in to ciphertext out, one register per round
    localparam int des_latency = 16;

    // Run configuration, sampled once when a start is accepted
    typedef struct packed {
        logic [63:0]      seed;       // First plaintext of the run
        logic [63:0]      polynomial; // LFSR feedback taps
        logic [63:0]      mask_in;    // Plaintext side of the approximation
        logic [63:0]      mask_out;   // Ciphertext side of the approximation
        logic [cnt_w-1:0] limit;      // Plaintexts in the run
    } bias_cfg_t;

    // Feistel halves plus the valid bit that walks along with them
    typedef struct packed {
        logic [31:0] l;
        logic [31:0] r;
        logic        valid;
    } des_stage_t;

    // XOR of every selected bit
    // Serves both as LFSR feedback and as the linear parity
    function automatic logic masked_parity(
        input logic [63:0] value,
        input logic [63:0] mask
    );
        return ^(value & mask);
    endfunction

endpackage

// ==== logic/bias_top.sv ====
module bias_top #(
    parameter logic [767:0] ROUND_KEYS = '0  // Fixed key, already expanded
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,    // Pulse, cfg valid alongside
    input  logic                       restart,  // Pulse
    input  bias_pkg::bias_cfg_t        cfg,
    output logic [bias_pkg::cnt_w-1:0] count,
    output logic                       done
);
    import bias_pkg::*;

    bias_cfg_t held_cfg;  // Config frozen for the run
    logic      capture;

    bias_config i_config (
        .clk      (clk),
        .rst_n    (rst_n),
        .restart  (restart),
        .capture  (capture),
        .cfg      (cfg),
        .held_cfg (held_cfg)
    );

    bias_block #(
        .ROUND_KEYS (ROUND_KEYS)
    ) i_block (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .restart  (restart),
        .held_cfg (held_cfg),
        .capture  (capture),
        .count    (count),
        .done     (done)
    );

endmodule

// ==== logic/des_pipeline.sv ====
module des_pipeline #(
    parameter logic [767:0] ROUND_KEYS = '0  // 16 x 48 bits, round 1 in the low slice
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        restart,      // Drops everything in flight
    input  logic [63:0] message,
    input  logic        msg_valid,
    output logic [63:0] cipher,
    output logic        cipher_valid  // des_latency cycles after msg_valid
);
    import bias_pkg::*;
    `include "des_tables.svh"

    logic [63:0] permuted;                  // After IP
    logic [63:0] preout;                    // R16 L16, before FP
    des_stage_t  stage [des_latency+1];     // stage[0] feeds round 1

    assign permuted = des_ip(message);
    assign stage[0] = '{l: permuted[63:32], r: permuted[31:0], valid: msg_valid};

    // One registered round per key slice
    for (genvar g = 0; g < des_latency; g++) begin : g_round
        des_round i_round (
            .clk       (clk),
            .rst_n     (rst_n),
            .restart   (restart),
            .round_key (ROUND_KEYS[48*g +: 48]),
            .stage_in  (stage[g]),
            .stage_out (stage[g+1])
        );
    end

    // Last round is not swapped in DES, undo the swap here
    assign preout       = {stage[des_latency].r, stage[des_latency].l};
    assign cipher       = des_fp(preout);
    assign cipher_valid = stage[des_latency].valid;

endmodule

// ==== logic/des_round.sv ====
module des_round (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 restart,   // Flushes the valid bit
    input  logic [47:0]          round_key, // Fixed per instance for now
    input  bias_pkg::des_stage_t stage_in,
    output bias_pkg::des_stage_t stage_out
);
    `include "des_tables.svh"

    logic [47:0] mixed;  // Expanded right half with the key applied
    logic [31:0] f_out;  // Round function result

    // Round function f(R, K)
    assign mixed = des_expand(stage_in.r) ^ round_key;
    assign f_out = des_perm_p(des_sbox(mixed));

    // Feistel swap
    always_ff @(posedge clk) begin
        stage_out.l <= stage_in.r;
        stage_out.r <= stage_in.l ^ f_out;
    end

    // Valid travels with the data, one cycle per round
    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            stage_out.valid <= 1'b0;
        end else begin
            stage_out.valid <= stage_in.valid;
        end
    end

endmodule

// ==== logic/msg_lfsr.sv ====
module msg_lfsr (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       restart,
    input  logic                       load,       // Takes seed and limit
    input  logic [63:0]                seed,
    input  logic [63:0]                polynomial, // Must stay stable during the run
    input  logic [bias_pkg::cnt_w-1:0] limit,
    output logic [63:0]                message,
    output logic                       msg_valid,
    output logic                       last        // With the final message
);
    import bias_pkg::*;

    logic [cnt_w-1:0] remaining;  // Messages left including the current one

    // Shift left, feedback into bit 0
    always_ff @(posedge clk) begin
        if (load) begin
            message <= seed;
        end else if (msg_valid) begin
            message <= {message[62:0], masked_parity(message, polynomial)};
        end
    end

    // Message counter, stops by itself after the last one
    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            remaining <= '0;
            msg_valid <= 1'b0;
        end else if (load) begin
            remaining <= limit;
            msg_valid <= (limit != '0);  // Empty run never goes valid
        end else if (msg_valid) begin
            remaining <= remaining - 1'b1;
            msg_valid <= (remaining != cnt_w'(1));
        end
    end

    assign last = msg_valid && (remaining == cnt_w'(1));

endmodule

// ==== test/bias_props.sv ====
module bias_props (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       restart,
    input logic                       done,
    input logic                       msg_valid,
    input logic                       cipher_valid,
    input logic [bias_pkg::cnt_w-1:0] count
);
    // Done only once nothing is left in flight
    done_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !msg_valid && !cipher_valid)
        else $error("done high while messages or ciphers were still valid");

    // Result frozen until a restart
    count_held_when_done: assert property (@(posedge clk) disable iff (!rst_n)
        (done && !restart) |=> $stable(count))
        else $error("count moved while done was high");

    // Register stage between cipher_valid and the counter
    count_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ($changed(count) && $past(rst_n) && !$past(restart)) |-> $past(cipher_valid, 2))
        else $error("count changed without cipher_valid two edges before");

endmodule

bind bias_block bias_props i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .restart      (restart),
    .done         (done),
    .msg_valid    (msg_valid),
    .cipher_valid (cipher_valid),
    .count        (count)
);

// ==== test/bias_tb.sv ====
module bias_tb;
    import bias_pkg::*;
    `include "des_tables.svh"

    // Arbitrary expanded key, round 1 in the low slice
    localparam logic [767:0] round_keys = {
        192'h1d8f6c205ba3_f4a2730e9c81_872de5b46f30_4bc01f97a2e8,
        192'hc8764a13e50f_2fb1d90c7a64_6e3c85f2b019_b0479ae3d65c,
        192'h9c52e7a04d3b_71f806bc2e95_a3d94f1068c7_5e0b27d9f41a,
        192'h3a1f0c9e6b27_d45e81c0f3a6_0b7c2e9d5f18_e6a493b1270c
    };
    localparam int total_msgs = 64 + 200 + 0 + 100 + 150 + 80;  // Sum of all run limits
    localparam int max_cycles = 20 + total_msgs + 6 * 64;        // Six runs, fill and drain each

    logic             clk = 1'b0;
    logic             rst_n;
    logic             start;
    logic             restart;
    bias_cfg_t        cfg;
    logic [cnt_w-1:0] count;
    logic             done;

    integer           seed = 32'h272882cf;
    int               errors = 0;
    int               cycles = 0;
    int               test_num = 0;
    logic             armed = 1'b0;  // Compare process is waiting for done
    logic [cnt_w-1:0] exp_count;
    logic [cnt_w-1:0] held_count;

    always #4 clk = ~clk;

    bias_top #(
        .ROUND_KEYS (round_keys)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .restart (restart),
        .cfg     (cfg),
        .count   (count),
        .done    (done)
    );

    // Plain software DES, one block
    function automatic logic [63:0] des_encrypt(input logic [63:0] pt);
        logic [63:0] perm;
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] t;
        perm = des_ip(pt);
        l    = perm[63:32];
        r    = perm[31:0];
        for (int i = 0; i < 16; i++) begin
            t = r;
            r = l ^ des_perm_p(des_sbox(des_expand(r) ^ round_keys[48*i +: 48]));
            l = t;
        end
        return des_fp({r, l});  // No swap after round 16
    endfunction

    // Walks the LFSR rule and counts pairs with odd combined parity
    function automatic logic [cnt_w-1:0] expected_count(input bias_cfg_t c);
        logic [63:0]      state;
        logic [63:0]      ct;
        logic [cnt_w-1:0] total;
        state = c.seed;
        total = '0;
        for (int unsigned k = 0; k < c.limit; k++) begin
            ct = des_encrypt(state);
            if ((^(state & c.mask_in)) ^ (^(ct & c.mask_out))) begin
                total = total + 1;
            end
            state = {state[62:0], ^(state & c.polynomial)};  // Shift left, feedback in bit 0
        end
        return total;
    endfunction

    function automatic bias_cfg_t random_cfg(input logic [cnt_w-1:0] lim);
        bias_cfg_t c;
        c.seed       = {$random(seed), $random(seed)};
        c.polynomial = {$random(seed), $random(seed)};
        c.mask_in    = {$random(seed), $random(seed)};
        c.mask_out   = {$random(seed), $random(seed)};
        c.limit      = lim;
        return c;
    endfunction

    // Restart first, so a finished block takes the new start
    task automatic launch(input bias_cfg_t c);
        restart = 1'b1;
        @(posedge clk);
        #2;
        restart = 1'b0;
        cfg     = c;
        start   = 1'b1;
        @(posedge clk);
        #2;
        start   = 1'b0;
    endtask

    task automatic expect_count(input logic [cnt_w-1:0] value);
        exp_count = value;
        armed     = 1'b1;
    endtask

    task automatic await_result();
        wait (!armed);
        @(posedge clk);
        #2;  // Back in step with the drive edge
    endtask

    task automatic close_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: failed", test_num, name);
        end
    endtask

    // Checks count at the first falling edge that sees done
    initial begin : compare
        forever begin
            @(negedge clk);
            if (armed && done) begin
                if (count !== exp_count) begin
                    $display("CHECK FAILED test %0d: count = %h, expected %h",
                             test_num, count, exp_count);
                    errors++;
                end
                armed = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout in test %0d, done did not arrive after %0d cycles",
                     test_num, cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        bias_cfg_t c;
        bias_cfg_t cfg_b;
        int        err_before;
        int        bit_sel;
        rst_n   = 1'b0;
        start   = 1'b0;
        restart = 1'b0;
        cfg     = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_num   = 1;  // Zero input mask, count is just one ciphertext bit
        err_before = errors;
        bit_sel    = $random(seed) & 63;
        c          = random_cfg(64);
        c.mask_in  = '0;
        c.mask_out = 64'd1 << bit_sel;
        launch(c);
        expect_count(expected_count(c));
        await_result();
        close_test("single output bit", err_before);

        test_num   = 2;
        err_before = errors;
        c          = random_cfg(200);
        launch(c);
        expect_count(expected_count(c));
        await_result();
        close_test("random masks", err_before);

        test_num   = 3;  // Empty run
        err_before = errors;
        c          = random_cfg(0);
        launch(c);
        expect_count('0);
        await_result();
        close_test("zero limit", err_before);

        test_num   = 4;
        err_before = errors;
        c          = random_cfg(100);
        cfg_b      = random_cfg(100);
        launch(c);
        expect_count(expected_count(c));
        repeat (30) @(posedge clk);
        #2;
        cfg   = cfg_b;  // New config and start mid-run, both ignored
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        wait (!armed);
        held_count = count;
        repeat (20) @(negedge clk);
        if (!done) begin
            $display("Test %0d: done fell while the block was idle", test_num);
            errors++;
        end
        if (count !== held_count) begin
            $display("CHECK FAILED test %0d: count = %h, expected %h",
                     test_num, count, held_count);
            errors++;
        end
        @(posedge clk);
        #2;
        close_test("ignored start and hold", err_before);

        test_num   = 5;
        err_before = errors;
        c          = random_cfg(150);
        launch(c);
        repeat (40) @(posedge clk);  // Well into the run with count already moving
        #2;
        restart = 1'b1;
        @(posedge clk);
        #2;
        restart = 1'b0;
        repeat (des_latency + 2) @(negedge clk);  // Anything still in flight would count by now
        if (count !== '0) begin
            $display("CHECK FAILED test %0d: count = %h, expected %h",
                     test_num, count, {cnt_w{1'b0}});
            errors++;
        end
        if (done) begin
            $display("Test %0d: done still high after restart", test_num);
            errors++;
        end
        @(posedge clk);
        #2;
        c     = random_cfg(80);  // Bare start pulse into the idle block
        cfg   = c;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        expect_count(expected_count(c));
        await_result();
        close_test("restart mid-run", err_before);

        $display("Summary: %0d tests, %0d errors", test_num, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
